// File: soc_pkg.sv
/* SoC system-control definitions */

package soc_pkg;

	// ------------------------------
	// Bus and register widths
	localparam int WB_ADR_W   = 32;
	localparam int DATA_W     = 32;
	localparam int CSR_ADR_W  = 14;
	localparam int CSR_BANK_W = 4;
	localparam int CSR_REG_W  = 10;

	// CSR address, raw on the bridge side, bank/register on the slave side
	typedef union packed {
		logic [CSR_ADR_W-1:0] raw;
		struct packed {
			logic [CSR_BANK_W-1:0] bank;
			logic [CSR_REG_W-1:0]  idx;
		} f;
	} csr_adr_u;

	// ------------------------------
	// Bank map
	localparam logic [CSR_BANK_W-1:0] SYSCTL_BANK = 4'd1;
	localparam logic [CSR_BANK_W-1:0] TIMER_BANK  = 4'd2;

	// System controller registers
	localparam logic [CSR_REG_W-1:0] SYSCTL_REG_IN    = 10'd0;
	localparam logic [CSR_REG_W-1:0] SYSCTL_REG_OUT   = 10'd1;
	localparam logic [CSR_REG_W-1:0] SYSCTL_REG_PEND  = 10'd2;
	localparam logic [CSR_REG_W-1:0] SYSCTL_REG_IRQEN = 10'd3;
	localparam logic [CSR_REG_W-1:0] SYSCTL_REG_RESET = 10'd4;
	localparam logic [CSR_REG_W-1:0] SYSCTL_REG_ID    = 10'd5;

	// Timer registers
	localparam logic [CSR_REG_W-1:0] TIMER_REG_CTRL    = 10'd0;
	localparam logic [CSR_REG_W-1:0] TIMER_REG_COMPARE = 10'd1;
	localparam logic [CSR_REG_W-1:0] TIMER_REG_COUNTER = 10'd2;

	// ------------------------------
	// Magic values and board sizes
	localparam logic [DATA_W-1:0] SYSTEM_ID      = 32'h4D4F4E45;
	localparam logic [DATA_W-1:0] HARD_RESET_KEY = 32'hDEADBEEF;

	localparam int N_BTN       = 3;
	localparam int N_LED       = 2;
	localparam int N_IRQ       = 2;
	localparam int FLASH_RST_W = 8;

endpackage

// File: reset_gen.sv
/* Reset sequencer */

`timescale 1ns/1ps

module reset_gen import soc_pkg::*; #(
	parameter int RST_DEBOUNCE_W = 20
) (
	input  logic             sys_clk,
	input  logic             trigger_reset,
	input  logic             hard_reset_i,
	input  logic [N_BTN-1:0] btn_i,
	output logic             sys_rst_o,
	output logic             flash_rst_n_o
);

	logic                      trigger;
	logic [RST_DEBOUNCE_W-1:0] debounce_cnt;
	logic [FLASH_RST_W-1:0]    flash_cnt;

	// All three buttons held together act as a reset button
	always_ff @(posedge sys_clk) begin
		trigger <= trigger_reset | hard_reset_i | (&btn_i);
	end

	// System reset stays high until the debounce counter drains
	always_ff @(posedge sys_clk) begin
		if (trigger) begin
			debounce_cnt <= '1;
		end else if (debounce_cnt != '0) begin
			debounce_cnt <= debounce_cnt - 1'b1;
		end
		sys_rst_o <= (debounce_cnt != '0);
	end

	// Flash comes out of reset first, it needs time before the first fetch
	always_ff @(posedge sys_clk) begin
		if (trigger) begin
			flash_cnt <= '0;
		end else if (!flash_cnt[FLASH_RST_W-1]) begin
			flash_cnt <= flash_cnt + 1'b1;
		end
	end

	assign flash_rst_n_o = flash_cnt[FLASH_RST_W-1];

endmodule

// File: wb_csr_bridge.sv
/* Wishbone to CSR bridge */

`timescale 1ns/1ps

module wb_csr_bridge import soc_pkg::*; (
	input  logic              sys_clk,
	input  logic              sys_rst,

	// Wishbone slave
	input  logic [WB_ADR_W-1:0] wb_adr_i,
	input  logic [DATA_W-1:0]   wb_dat_i,
	input  logic                wb_we_i,
	input  logic                wb_cyc_i,
	input  logic                wb_stb_i,
	output logic [DATA_W-1:0]   wb_dat_o,
	output logic                wb_ack_o,

	// CSR master
	output csr_adr_u            csr_a_o,
	output logic                csr_we_o,
	output logic [DATA_W-1:0]   csr_dw_o,
	input  logic [DATA_W-1:0]   csr_dr_i
);

	// ------------------------------
	// Sequencer states
	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_ACCESS = 2'd1;
	localparam logic [1:0] ST_ACK    = 2'd2;

	logic [1:0] state;
	logic       req;

	assign req = wb_cyc_i & wb_stb_i;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req) begin
						state <= ST_ACCESS;
					end
				end
				ST_ACCESS: state <= ST_ACK;
				// Back to idle for one cycle, stb may still be high here
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Write strobe lasts exactly one cycle
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_we_o <= 1'b0;
		end else begin
			csr_we_o <= (state == ST_IDLE) & req & wb_we_i;
		end
	end

	// Address and write data held until the next access
	always_ff @(posedge sys_clk) begin
		if ((state == ST_IDLE) && req) begin
			csr_a_o.raw <= wb_adr_i[CSR_ADR_W+1:2];
			csr_dw_o    <= wb_dat_i;
		end
	end

	assign wb_ack_o = (state == ST_ACK);

	// Slaves registered their read word at the access edge, so it is
	// already stable during the ack cycle
	assign wb_dat_o = wb_ack_o ? csr_dr_i : '0;

endmodule

// File: sysctl_regs.sv
/* System controller CSR bank */

`timescale 1ns/1ps

module sysctl_regs import soc_pkg::*; (
	input  logic              sys_clk,
	input  logic              sys_rst,

	input  csr_adr_u          csr_a_i,
	input  logic              csr_we_i,
	input  logic [DATA_W-1:0] csr_dw_i,
	output logic [DATA_W-1:0] csr_dr_o,

	input  logic [N_BTN-1:0]  btn_i,
	output logic [N_LED-1:0]  led_o,
	output logic              gpio_irq_o,
	output logic              hard_reset_o
);

	logic [N_BTN-1:0] btn_meta;
	logic [N_BTN-1:0] btn_sync;
	logic [N_BTN-1:0] btn_prev;
	logic [N_BTN-1:0] pend;
	logic [N_BTN-1:0] irqen;
	logic             sel;
	logic             wr;

	assign sel = (csr_a_i.f.bank == SYSCTL_BANK);
	assign wr  = sel & csr_we_i;

	// ------------------------------
	// Button synchronizer and edge detect
	always_ff @(posedge sys_clk) begin
		btn_meta <= btn_i;
		btn_sync <= btn_meta;
		btn_prev <= btn_sync;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pend         <= '0;
			irqen        <= '0;
			led_o        <= '0;
			hard_reset_o <= 1'b0;
		end else begin
			hard_reset_o <= 1'b0;
			// New edges win over a clear in the same cycle
			if (wr && (csr_a_i.f.idx == SYSCTL_REG_PEND)) begin
				pend <= (pend & ~csr_dw_i[N_BTN-1:0]) | (btn_sync & ~btn_prev);
			end else begin
				pend <= pend | (btn_sync & ~btn_prev);
			end
			if (wr) begin
				case (csr_a_i.f.idx)
					SYSCTL_REG_OUT:   led_o <= csr_dw_i[N_LED-1:0];
					SYSCTL_REG_IRQEN: irqen <= csr_dw_i[N_BTN-1:0];
					SYSCTL_REG_RESET: hard_reset_o <= (csr_dw_i == HARD_RESET_KEY);
					default: ;
				endcase
			end
		end
	end

	assign gpio_irq_o = |(pend & irqen);

	// ------------------------------
	// Read back
	always_ff @(posedge sys_clk) begin
		csr_dr_o <= '0;
		if (sel) begin
			case (csr_a_i.f.idx)
				SYSCTL_REG_IN:    csr_dr_o <= {{(DATA_W-N_BTN){1'b0}}, btn_sync};
				SYSCTL_REG_OUT:   csr_dr_o <= {{(DATA_W-N_LED){1'b0}}, led_o};
				SYSCTL_REG_PEND:  csr_dr_o <= {{(DATA_W-N_BTN){1'b0}}, pend};
				SYSCTL_REG_IRQEN: csr_dr_o <= {{(DATA_W-N_BTN){1'b0}}, irqen};
				SYSCTL_REG_ID:    csr_dr_o <= SYSTEM_ID;
				default:          csr_dr_o <= '0;
			endcase
		end
	end

endmodule

// File: timer_ctl.sv
/* Compare timer CSR bank */

`timescale 1ns/1ps

module timer_ctl import soc_pkg::*; (
	input  logic              sys_clk,
	input  logic              sys_rst,

	input  csr_adr_u          csr_a_i,
	input  logic              csr_we_i,
	input  logic [DATA_W-1:0] csr_dw_i,
	output logic [DATA_W-1:0] csr_dr_o,

	output logic              timer_irq_o
);

	logic              en;
	logic              autoreload;
	logic [DATA_W-1:0] compare;
	logic [DATA_W-1:0] counter;
	logic              sel;
	logic              wr;
	logic              match;

	assign sel   = (csr_a_i.f.bank == TIMER_BANK);
	assign wr    = sel & csr_we_i;
	assign match = en & (counter == compare);

	// ------------------------------
	// Counter and control
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			en          <= 1'b0;
			autoreload  <= 1'b0;
			compare     <= '0;
			counter     <= '0;
			timer_irq_o <= 1'b0;
		end else begin
			timer_irq_o <= match;

			if (match) begin
				counter <= '0;
				// One-shot mode stops itself
				if (!autoreload) begin
					en <= 1'b0;
				end
			end else if (en) begin
				counter <= counter + 1'b1;
			end

			// Register writes take priority over the count
			if (wr) begin
				case (csr_a_i.f.idx)
					TIMER_REG_CTRL: begin
						en         <= csr_dw_i[0];
						autoreload <= csr_dw_i[1];
					end
					TIMER_REG_COMPARE: compare <= csr_dw_i;
					TIMER_REG_COUNTER: counter <= csr_dw_i;
					default: ;
				endcase
			end
		end
	end

	// ------------------------------
	// Read back
	always_ff @(posedge sys_clk) begin
		csr_dr_o <= '0;
		if (sel) begin
			case (csr_a_i.f.idx)
				TIMER_REG_CTRL:    csr_dr_o <= {{(DATA_W-2){1'b0}}, autoreload, en};
				TIMER_REG_COMPARE: csr_dr_o <= compare;
				TIMER_REG_COUNTER: csr_dr_o <= counter;
				default:           csr_dr_o <= '0;
			endcase
		end
	end

endmodule

// File: soc_top.sv
/* SoC system-control top level */

`timescale 1ns/1ps

module soc_top import soc_pkg::*; #(
	parameter int RST_DEBOUNCE_W = 20
) (
	input  logic                sys_clk,
	input  logic                trigger_reset,

	// Wishbone slave port
	input  logic [WB_ADR_W-1:0] wb_adr_i,
	input  logic [DATA_W-1:0]   wb_dat_i,
	input  logic                wb_we_i,
	input  logic                wb_cyc_i,
	input  logic                wb_stb_i,
	output logic [DATA_W-1:0]   wb_dat_o,
	output logic                wb_ack_o,

	// Board I/O
	input  logic [N_BTN-1:0]    btn_i,
	output logic [N_LED-1:0]    led_o,
	output logic [N_IRQ-1:0]    irq_o,
	output logic                sys_rst_o,
	output logic                flash_rst_n_o
);

	logic              sys_rst;
	logic              hard_reset;
	logic              gpio_irq;
	logic              timer_irq;

	csr_adr_u          csr_a;
	logic              csr_we;
	logic [DATA_W-1:0] csr_dw;
	logic [DATA_W-1:0] csr_dr;
	logic [DATA_W-1:0] csr_dr_sysctl;
	logic [DATA_W-1:0] csr_dr_timer;

	// ------------------------------
	// Reset
	reset_gen #(
		.RST_DEBOUNCE_W (RST_DEBOUNCE_W)
	) reset_gen0 (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.hard_reset_i  (hard_reset),
		.btn_i         (btn_i),
		.sys_rst_o     (sys_rst),
		.flash_rst_n_o (flash_rst_n_o)
	);

	assign sys_rst_o = sys_rst;

	// ------------------------------
	// Bus bridge and CSR slaves
	// Unselected banks return zero, so a plain OR merges the read data
	assign csr_dr = csr_dr_sysctl | csr_dr_timer;

	wb_csr_bridge bridge0 (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_we_i  (wb_we_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.csr_a_o  (csr_a),
		.csr_we_o (csr_we),
		.csr_dw_o (csr_dw),
		.csr_dr_i (csr_dr)
	);

	sysctl_regs sysctl0 (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.csr_a_i      (csr_a),
		.csr_we_i     (csr_we),
		.csr_dw_i     (csr_dw),
		.csr_dr_o     (csr_dr_sysctl),
		.btn_i        (btn_i),
		.led_o        (led_o),
		.gpio_irq_o   (gpio_irq),
		.hard_reset_o (hard_reset)
	);

	timer_ctl timer0 (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.csr_a_i     (csr_a),
		.csr_we_i    (csr_we),
		.csr_dw_i    (csr_dw),
		.csr_dr_o    (csr_dr_timer),
		.timer_irq_o (timer_irq)
	);

	// Bit 0 GPIO, bit 1 timer
	assign irq_o = {timer_irq, gpio_irq};

endmodule

// File: tb_soc_top.sv
/* SoC system-control testbench */

`timescale 1ns/1ps

module tb_soc_top import soc_pkg::*; ();

	localparam int RST_DEBOUNCE_W = 8;
	localparam int TIMEOUT_CYCLES = 5000;
	localparam int RST_WAIT_MAX   = (1 << RST_DEBOUNCE_W) + 16;
	localparam int ACK_WAIT_MAX   = 16;
	localparam int POLL_MAX       = 16;
	localparam int TIMER_WAIT_MAX = 64;
	localparam int TIMER_COMPARE  = 20;

	localparam logic [CSR_BANK_W-1:0] UNUSED_BANK = 4'd5;

	logic                sys_clk;
	logic                trigger_reset;
	logic [WB_ADR_W-1:0] wb_adr_i;
	logic [DATA_W-1:0]   wb_dat_i;
	logic                wb_we_i;
	logic                wb_cyc_i;
	logic                wb_stb_i;
	logic [DATA_W-1:0]   wb_dat_o;
	logic                wb_ack_o;
	logic [N_BTN-1:0]    btn_i;
	logic [N_LED-1:0]    led_o;
	logic [N_IRQ-1:0]    irq_o;
	logic                sys_rst_o;
	logic                flash_rst_n_o;

	integer seed = 32'h66da;
	int     cycle_cnt = 0;

	soc_top #(
		.RST_DEBOUNCE_W (RST_DEBOUNCE_W)
	) dut0 (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.wb_adr_i      (wb_adr_i),
		.wb_dat_i      (wb_dat_i),
		.wb_we_i       (wb_we_i),
		.wb_cyc_i      (wb_cyc_i),
		.wb_stb_i      (wb_stb_i),
		.wb_dat_o      (wb_dat_o),
		.wb_ack_o      (wb_ack_o),
		.btn_i         (btn_i),
		.led_o         (led_o),
		.irq_o         (irq_o),
		.sys_rst_o     (sys_rst_o),
		.flash_rst_n_o (flash_rst_n_o)
	);

	always #4 sys_clk = ~sys_clk;

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_eq(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		assert (got === exp) else
			stop_with_failure($sformatf("Error: %s = 0x%08h, expected 0x%08h", name, got, exp));
	endtask

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			stop_with_failure($sformatf("Timeout, run still busy after %0d cycles", cycle_cnt));
		end
	end

	// ------------------------------
	// Output checks on the falling edge where DUT outputs are settled
	// Slave registers clear one edge after sys_rst_o rises
	reset_quiet: assert property (@(negedge sys_clk)
		(sys_rst_o && $past(sys_rst_o)) |-> (!wb_ack_o && led_o == '0 && irq_o == '0))
		else stop_with_failure($sformatf(
			"Error: in reset wb_ack_o = 0x%0h led_o = 0x%0h irq_o = 0x%0h, expected 0x0",
			wb_ack_o, led_o, irq_o));

	flash_first: assert property (@(negedge sys_clk) $fell(sys_rst_o) |-> flash_rst_n_o)
		else stop_with_failure("Error: flash_rst_n_o = 0x0 when sys_rst_o fell, expected 0x1");

	ack_single: assert property (@(negedge sys_clk) !(wb_ack_o && $past(wb_ack_o)))
		else stop_with_failure("wb_ack_o stayed high for more than one cycle");

	timer_pulse_single: assert property (@(negedge sys_clk) !(irq_o[1] && $past(irq_o[1])))
		else stop_with_failure("Timer interrupt stayed high for more than one cycle");

	// ------------------------------
	// Bus access that starts and returns on a falling edge
	task automatic wb_access(input logic we, input logic [WB_ADR_W-1:0] adr,
			input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat);
		int lat;
		wb_adr_i = adr;
		wb_dat_i = wdat;
		wb_we_i  = we;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		lat = 0;
		do begin
			@(negedge sys_clk);
			lat++;
		end while (!wb_ack_o && lat < ACK_WAIT_MAX);
		assert (wb_ack_o) else stop_with_failure("No wb_ack_o for a Wishbone request");
		check_eq("wb_ack_o latency", DATA_W'(lat), 32'd2);
		rdat     = wb_dat_o;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		@(negedge sys_clk);
	endtask

	// CSR address sits in word address bits 15:2
	function automatic logic [WB_ADR_W-1:0] csr_addr(input logic [CSR_BANK_W-1:0] bank,
			input logic [CSR_REG_W-1:0] idx);
		return {{(WB_ADR_W-CSR_ADR_W-2){1'b0}}, bank, idx, 2'b00};
	endfunction

	task automatic wb_write(input logic [CSR_BANK_W-1:0] bank, input logic [CSR_REG_W-1:0] idx,
			input logic [DATA_W-1:0] data);
		logic [DATA_W-1:0] ignored;
		wb_access(1'b1, csr_addr(bank, idx), data, ignored);
	endtask

	task automatic wb_read(input logic [CSR_BANK_W-1:0] bank, input logic [CSR_REG_W-1:0] idx,
			output logic [DATA_W-1:0] data);
		wb_access(1'b0, csr_addr(bank, idx), '0, data);
	endtask

	task automatic read_check(input logic [CSR_BANK_W-1:0] bank,
			input logic [CSR_REG_W-1:0] idx, input logic [DATA_W-1:0] exp, input string name);
		logic [DATA_W-1:0] data;
		wb_read(bank, idx, data);
		check_eq(name, data, exp);
	endtask

	// Two synchronizer stages sit between btn_i and IN
	task automatic wait_btn_in(input logic [N_BTN-1:0] val);
		logic [DATA_W-1:0] data;
		int n;
		n = 0;
		do begin
			wb_read(SYSCTL_BANK, SYSCTL_REG_IN, data);
			n++;
		end while (data !== DATA_W'(val) && n < POLL_MAX);
		check_eq("IN", data, DATA_W'(val));
	endtask

	task automatic wait_timer_irq(output int cycles);
		cycles = 0;
		do begin
			@(negedge sys_clk);
			cycles++;
		end while (!irq_o[1] && cycles < TIMER_WAIT_MAX);
		assert (irq_o[1]) else stop_with_failure("Timer interrupt did not fire");
	endtask

	task automatic wait_reset_done();
		int n;
		n = 0;
		while (sys_rst_o !== 1'b1 && n < POLL_MAX) begin
			@(negedge sys_clk);
			n++;
		end
		assert (sys_rst_o === 1'b1) else stop_with_failure("sys_rst_o never went high");
		check_eq("flash_rst_n_o", DATA_W'(flash_rst_n_o), 32'h0);
		// A read request held through reset gets no ack
		wb_adr_i = csr_addr(SYSCTL_BANK, SYSCTL_REG_ID);
		wb_we_i  = 1'b0;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		n = 0;
		while (sys_rst_o && n < RST_WAIT_MAX) begin
			@(negedge sys_clk);
			n++;
		end
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		assert (!sys_rst_o) else stop_with_failure("sys_rst_o did not fall after debounce");
		@(negedge sys_clk);
	endtask

	// ------------------------------
	// Test sequence
	initial begin : stimulus
		logic [DATA_W-1:0] rnd;
		int gap;
		sys_clk       = 1'b0;
		trigger_reset = 1'b1;
		wb_adr_i      = '0;
		wb_dat_i      = '0;
		wb_we_i       = 1'b0;
		wb_cyc_i      = 1'b0;
		wb_stb_i      = 1'b0;
		btn_i         = '0;
		repeat (2) @(negedge sys_clk);
		trigger_reset = 1'b0;
		wait_reset_done();

		// Decode and an unmapped bank that reads zero
		read_check(SYSCTL_BANK, SYSCTL_REG_ID, SYSTEM_ID, "ID");
		read_check(UNUSED_BANK, 10'd0, '0, "bank 5 reg 0");
		read_check(UNUSED_BANK, SYSCTL_REG_ID, '0, "bank 5 reg 5");

		repeat (4) begin
			rnd = $random(seed);
			wb_write(SYSCTL_BANK, SYSCTL_REG_OUT, rnd);
			check_eq("led_o", DATA_W'(led_o), DATA_W'(rnd[N_LED-1:0]));
			read_check(SYSCTL_BANK, SYSCTL_REG_OUT, DATA_W'(rnd[N_LED-1:0]), "OUT");
		end

		// Interrupt enabled for button 0 only
		wb_write(SYSCTL_BANK, SYSCTL_REG_IRQEN, 32'h1);
		btn_i = 3'b001;
		wait_btn_in(3'b001);
		read_check(SYSCTL_BANK, SYSCTL_REG_PEND, 32'h1, "PEND");
		check_eq("irq_o", DATA_W'(irq_o), 32'h1);
		wb_write(SYSCTL_BANK, SYSCTL_REG_PEND, 32'h1);
		check_eq("irq_o", DATA_W'(irq_o), 32'h0);
		read_check(SYSCTL_BANK, SYSCTL_REG_PEND, 32'h0, "PEND");
		btn_i = 3'b011;
		wait_btn_in(3'b011);
		read_check(SYSCTL_BANK, SYSCTL_REG_PEND, 32'h2, "PEND");
		check_eq("irq_o", DATA_W'(irq_o), 32'h0);
		btn_i = 3'b000;
		wait_btn_in(3'b000);
		wb_write(SYSCTL_BANK, SYSCTL_REG_PEND, 32'h7);
		read_check(SYSCTL_BANK, SYSCTL_REG_PEND, 32'h0, "PEND");

		// One-shot timer
		wb_write(TIMER_BANK, TIMER_REG_COMPARE, TIMER_COMPARE);
		wb_write(TIMER_BANK, TIMER_REG_COUNTER, 32'h0);
		wb_write(TIMER_BANK, TIMER_REG_CTRL, 32'h1);
		wait_timer_irq(gap);
		repeat (2 * TIMER_COMPARE + 4) begin
			@(negedge sys_clk);
			assert (!irq_o[1]) else stop_with_failure("One-shot timer fired a second time");
		end
		read_check(TIMER_BANK, TIMER_REG_CTRL, 32'h0, "CTRL");
		read_check(TIMER_BANK, TIMER_REG_COUNTER, 32'h0, "COUNTER");

		// Auto-reload wraps the counter to 0 on match so the period is COMPARE + 1
		wb_write(TIMER_BANK, TIMER_REG_CTRL, 32'h3);
		wait_timer_irq(gap);
		wait_timer_irq(gap);
		check_eq("timer irq period", DATA_W'(gap), DATA_W'(TIMER_COMPARE + 1));
		read_check(TIMER_BANK, TIMER_REG_CTRL, 32'h3, "CTRL");
		wb_write(TIMER_BANK, TIMER_REG_CTRL, 32'h0);

		// Pending GPIO interrupt for the hard reset to clear
		btn_i = 3'b001;
		wait_btn_in(3'b001);
		check_eq("irq_o", DATA_W'(irq_o), 32'h1);

		// Hard reset with a wrong key first
		wb_write(SYSCTL_BANK, SYSCTL_REG_OUT, 32'h3);
		rnd = $random(seed);
		wb_write(SYSCTL_BANK, SYSCTL_REG_RESET, HARD_RESET_KEY ^ (rnd | 32'h1));
		repeat (8) begin
			@(negedge sys_clk);
			assert (!sys_rst_o) else stop_with_failure("A wrong reset key reset the system");
		end
		wb_write(SYSCTL_BANK, SYSCTL_REG_RESET, HARD_RESET_KEY);
		wait_reset_done();
		check_eq("led_o", DATA_W'(led_o), 32'h0);
		read_check(SYSCTL_BANK, SYSCTL_REG_OUT, 32'h0, "OUT");

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: vlog.f
soc_pkg.sv
reset_gen.sv
wb_csr_bridge.sv
sysctl_regs.sv
timer_ctl.sv
soc_top.sv
tb_soc_top.sv

// File: run.sh
#!/bin/sh
# Compile and run the SoC system-control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_soc_top -f vlog.f -o tb_soc_top
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/tb_soc_top
status=$?
if [ "$status" -ne 0 ]; then
	echo "Testbench run failed with status $status"
	exit "$status"
fi

exit 0
